// File: Bender.yml
package:
  name: tlb_cache

sources:
  - files:
      - src/cache_geom_pkg.sv
      - src/cache_ctl_pkg.sv
      - src/cache_ctrl.sv
      - src/tlb_array.sv
      - src/cache_array.sv
      - src/mem_port.sv
      - src/cache_top.sv
  - target: test
    files:
      - dv/cache_checker.sv
      - dv/tb_cache_top.sv

// File: dv/cache_checker.sv
`default_nettype none

module cache_checker (
  input wire                                CPU_CLK,
  input wire                                RST,
  input wire                                req,
  input wire cache_ctl_pkg::cache_op_e      op,
  input wire                                busy,
  input wire                                done,
  input wire                                fault,
  input wire                                mem_req,
  input wire                                mem_we,
  input wire [cache_geom_pkg::paddr_w-1:0]  mem_addr,
  input wire [cache_geom_pkg::data_w-1:0]   mem_wdata,
  input wire                                mem_ack
);

  int unsigned fail_count = 0;

  busy_after_req: assert property (@(posedge CPU_CLK) disable iff (!RST)
    req && !busy |=> busy)
  else
  begin
    fail_count++;
    $error("busy did not rise in the cycle after req");
  end

  done_one_cycle: assert property (@(posedge CPU_CLK) disable iff (!RST)
    done |=> !done)
  else
  begin
    fail_count++;
    $error("done stayed high for more than one cycle");
  end

  // The request and its fields hold while memory withholds the acknowledge.
  mem_fields_stable: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we)
      && $stable(mem_wdata))
  else
  begin
    fail_count++;
    $error("memory request changed before its acknowledge");
  end

  no_mem_on_fault: assert property (@(posedge CPU_CLK) disable iff (!RST)
    fault |-> !mem_req)
  else
  begin
    fail_count++;
    $error("memory request seen during a translation fault");
  end

  no_mem_on_tlb_load: assert property (@(posedge CPU_CLK) disable iff (!RST)
    req && !busy && (op == cache_ctl_pkg::op_tlb_load) |=> !mem_req ##1 !mem_req)
  else
  begin
    fail_count++;
    $error("memory request seen during a TLB load");
  end

  reset_outputs_low: assert property (@(posedge CPU_CLK)
    !RST |=> !busy && !done && !fault && !mem_req && !mem_we)
  else
  begin
    fail_count++;
    $error("control outputs not low after reset");
  end

endmodule

bind cache_top cache_checker checker0 (
  .CPU_CLK   (CPU_CLK),
  .RST       (RST),
  .req       (req),
  .op        (op),
  .busy      (busy),
  .done      (done),
  .fault     (fault),
  .mem_req   (mem_req),
  .mem_we    (mem_we),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .mem_ack   (mem_ack)
);

`default_nettype wire

// File: dv/tb_cache_top.sv
`default_nettype none

module tb_cache_top;

  localparam int done_timeout = 200;

  logic                               CPU_CLK;
  logic                               RST;
  logic                               req;
  cache_ctl_pkg::cache_op_e           op;
  logic [cache_geom_pkg::vaddr_w-1:0] vaddr;
  logic [cache_geom_pkg::data_w-1:0]  wdata;
  logic                               busy;
  logic                               done;
  logic [cache_geom_pkg::data_w-1:0]  rdata;
  logic                               fault;
  logic                               mem_req;
  logic                               mem_we;
  logic [cache_geom_pkg::paddr_w-1:0] mem_addr;
  logic [cache_geom_pkg::data_w-1:0]  mem_wdata;
  logic                               mem_ack;
  logic [cache_geom_pkg::data_w-1:0]  mem_rdata;

  // Shadow TLB and shadow cache tags.
  logic [cache_geom_pkg::vtag_w-1:0] tlb_vtag [cache_geom_pkg::tlb_depth];
  logic [cache_geom_pkg::ppn_w-1:0]  tlb_ppn [cache_geom_pkg::tlb_depth];
  logic                              tlb_valid [cache_geom_pkg::tlb_depth];
  logic [cache_geom_pkg::ppn_w-1:0]  line_tag [cache_geom_pkg::line_count];
  logic                              line_valid [cache_geom_pkg::line_count];

  logic [31:0] shadow_mem [int]; // Words the testbench expects to have been written.
  logic [31:0] mem_written [int]; // Words the memory model actually received.
  logic [cache_geom_pkg::paddr_w-1:0] log_addr [$];
  logic                               log_we [$];
  logic [31:0]                        log_wdata [$];

  logic [31:0] delay_lfsr;
  logic [31:0] stim_lfsr;
  logic        mem_pending;
  int          ack_wait;

  cache_top dut0 (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .req       (req),
    .op        (op),
    .vaddr     (vaddr),
    .wdata     (wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .fault     (fault),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #20 CPU_CLK = ~CPU_CLK;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value = {value[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  // Unwritten memory holds a pattern of the whole word address.
  function automatic logic [31:0] mem_pattern(input logic [23:0] word_addr);
    mem_pattern = (word_addr * 32'h9e37_79b1) ^ {8'h5a, word_addr};
  endfunction

  function automatic logic [31:0] model_word(input logic [23:0] word_addr);
    if (mem_written.exists(int'(word_addr)))
      return mem_written[int'(word_addr)];
    return mem_pattern(word_addr);
  endfunction

  function automatic logic [31:0] expected_word(input logic [23:0] word_addr);
    if (shadow_mem.exists(int'(word_addr)))
      return shadow_mem[int'(word_addr)];
    return mem_pattern(word_addr);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    fail_run($sformatf("CHECK FAILED %s: expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
      value_mismatch(name, expected, actual);
  endtask

  always @(negedge CPU_CLK)
  begin
    if (dut0.checker0.fail_count != 0)
      fail_run("a protocol assertion in the bound checker failed");
  end

  // Memory model with a random acknowledge delay of 0 to 3 cycles.
  always @(negedge CPU_CLK)
  begin : mem_model
    logic [31:0] delay_bits;
    if (mem_ack)
      mem_ack = 1'b0;
    else if (mem_req === 1'b1)
    begin
      if (!mem_pending)
      begin
        mem_pending = 1'b1;
        draw_bits(delay_lfsr, 2, delay_bits);
        ack_wait = int'(delay_bits);
        log_addr.push_back(mem_addr);
        log_we.push_back(mem_we);
        log_wdata.push_back(mem_wdata);
      end
      if (ack_wait == 0)
      begin
        if (mem_we)
          mem_written[int'(mem_addr[25:2])] = mem_wdata;
        else
          mem_rdata = model_word(mem_addr[25:2]);
        mem_ack = 1'b1;
        mem_pending = 1'b0;
      end
      else
        ack_wait--;
    end
  end

  // Issues one request at a falling edge and checks it against the shadow model.
  task automatic do_request(input string name, input cache_ctl_pkg::cache_op_e kind,
                            input logic [31:0] va, input logic [31:0] wd);
    logic [7:0]  tidx;
    logic [6:0]  line;
    logic        exp_fault;
    logic        exp_hit;
    logic [25:0] pa;
    logic [31:0] exp_data;
    int          cycles;
    tidx = va[17:10];
    line = va[9:3];
    exp_fault = !tlb_valid[tidx] || (tlb_vtag[tidx] != va[31:18]);
    pa = {tlb_ppn[tidx], va[9:0]};
    exp_hit = line_valid[line] && (line_tag[line] == tlb_ppn[tidx]);
    exp_data = expected_word(pa[25:2]);
    log_addr.delete();
    log_we.delete();
    log_wdata.delete();
    req = 1'b1;
    op = kind;
    vaddr = va;
    wdata = wd;
    @(negedge CPU_CLK);
    req = 1'b0;
    cycles = 1;
    check_value({name, " busy"}, 1, busy);
    while (done !== 1'b1)
    begin
      if (cycles >= done_timeout)
        fail_run($sformatf("%s: timed out waiting for done", name));
      @(negedge CPU_CLK);
      cycles++;
    end
    if (kind == cache_ctl_pkg::op_tlb_load)
    begin
      check_value({name, " latency"}, 2, cycles);
      check_value({name, " memory accesses"}, 0, log_addr.size());
      tlb_vtag[tidx] = wd[29:16];
      tlb_ppn[tidx] = wd[15:0];
      tlb_valid[tidx] = 1'b1;
    end
    else if (exp_fault)
    begin
      check_value({name, " fault"}, 1, fault);
      check_value({name, " latency"}, 3, cycles);
      check_value({name, " memory accesses"}, 0, log_addr.size());
    end
    else
    begin
      check_value({name, " fault"}, 0, fault);
      if (kind == cache_ctl_pkg::op_write)
      begin
        check_value({name, " memory accesses"}, 1, log_addr.size());
        check_value({name, " mem_we"}, 1, log_we[0]);
        check_value({name, " mem_addr"}, pa, log_addr[0]);
        check_value({name, " mem_wdata"}, wd, log_wdata[0]);
        shadow_mem[int'(pa[25:2])] = wd;
      end
      else if (exp_hit)
      begin
        check_value({name, " latency"}, 3, cycles);
        check_value({name, " memory accesses"}, 0, log_addr.size());
        check_value({name, " rdata"}, exp_data, rdata);
      end
      else
      begin
        check_value({name, " memory accesses"}, 2, log_addr.size());
        check_value({name, " even mem_addr"}, {pa[25:3], 3'b000}, log_addr[0]);
        check_value({name, " even mem_we"}, 0, log_we[0]);
        check_value({name, " odd mem_addr"}, {pa[25:3], 3'b100}, log_addr[1]);
        check_value({name, " odd mem_we"}, 0, log_we[1]);
        check_value({name, " rdata"}, exp_data, rdata);
        line_valid[line] = 1'b1; // Refill brings in the line under the new page.
        line_tag[line] = tlb_ppn[tidx];
      end
    end
  endtask

  initial
  begin
    logic [31:0] va_a;
    logic [31:0] va_b;
    logic [31:0] va_bad;
    logic [31:0] va;
    logic [31:0] bits;
    logic [31:0] kind;
    logic [31:0] data;
    logic [2:0]  line3;
    logic        word;
    int          p;
    logic [13:0] page_vtag [4];
    logic [7:0]  page_idx [4];
    CPU_CLK = 1'b0;
    RST = 1'b0;
    req = 1'b0;
    op = cache_ctl_pkg::op_read;
    vaddr = '0;
    wdata = '0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    mem_pending = 1'b0;
    ack_wait = 0;
    delay_lfsr = 32'he64d;
    stim_lfsr = 32'he64d;
    for (int i = 0; i < cache_geom_pkg::tlb_depth; i++)
      tlb_valid[i] = 1'b0;
    for (int i = 0; i < cache_geom_pkg::line_count; i++)
      line_valid[i] = 1'b0;
    repeat (3) @(negedge CPU_CLK);
    RST = 1'b1;

    check_value("reset busy", 0, busy);
    check_value("reset done", 0, done);
    check_value("reset mem_req", 0, mem_req);
    check_value("reset mem_we", 0, mem_we);
    do_request("reset read", cache_ctl_pkg::op_read, 32'h0123_4568, 32'h0);

    va_a = {14'h0a3c, 8'h45, 10'h2a8};
    va_b = {14'h0a3c, 8'h45, 10'h100};
    va_bad = {14'h0a3d, 8'h45, 10'h2a8};
    do_request("tlb load a", cache_ctl_pkg::op_tlb_load, va_a, {2'b00, 14'h0a3c, 16'h3a5c});
    do_request("read miss a", cache_ctl_pkg::op_read, va_a, 32'h0);
    do_request("read hit odd", cache_ctl_pkg::op_read, va_a ^ 32'h4, 32'h0);
    do_request("read hit even", cache_ctl_pkg::op_read, va_a, 32'h0);

    do_request("write hit a", cache_ctl_pkg::op_write, va_a, 32'hc0de_1234);
    do_request("read after write hit", cache_ctl_pkg::op_read, va_a, 32'h0);
    do_request("write miss b", cache_ctl_pkg::op_write, va_b, 32'h7e57_00b5);
    do_request("read refetch b", cache_ctl_pkg::op_read, va_b, 32'h0);

    do_request("read tag mismatch", cache_ctl_pkg::op_read, va_bad, 32'h0);
    do_request("write tag mismatch", cache_ctl_pkg::op_write, va_bad, 32'hdead_0001);
    do_request("tlb reload a", cache_ctl_pkg::op_tlb_load, va_a, {2'b00, 14'h0a3c, 16'h1b07});
    do_request("read after reload", cache_ctl_pkg::op_read, va_a, 32'h0);

    // Several pages on distinct TLB entries, random operations under random delays.
    for (int i = 0; i < 4; i++)
    begin
      draw_bits(stim_lfsr, 14, bits);
      page_vtag[i] = bits[13:0];
      page_idx[i] = 8'h11 + 8'(i) * 8'h3b;
      draw_bits(stim_lfsr, 16, bits);
      do_request("random tlb load", cache_ctl_pkg::op_tlb_load,
                 {page_vtag[i], page_idx[i], 10'h0}, {2'b00, page_vtag[i], bits[15:0]});
    end
    for (int n = 0; n < 64; n++)
    begin
      draw_bits(stim_lfsr, 2, bits);
      p = int'(bits);
      draw_bits(stim_lfsr, 3, bits);
      line3 = bits[2:0];
      draw_bits(stim_lfsr, 1, bits);
      word = bits[0];
      draw_bits(stim_lfsr, 3, kind);
      draw_bits(stim_lfsr, 32, data);
      va = {page_vtag[p], page_idx[p], line3, 4'h6, word, 2'b00};
      case (kind[2:0])
        3'd0, 3'd1, 3'd2, 3'd3:
          do_request("random read", cache_ctl_pkg::op_read, va, 32'h0);
        3'd4, 3'd5:
          do_request("random write", cache_ctl_pkg::op_write, va, data);
        3'd6:
        begin
          va[31:18] = va[31:18] ^ 14'h1; // Tag no longer matches the entry.
          if (data[0])
            do_request("random fault write", cache_ctl_pkg::op_write, va, data);
          else
            do_request("random fault read", cache_ctl_pkg::op_read, va, 32'h0);
        end
        default:
          do_request("random tlb reload", cache_ctl_pkg::op_tlb_load, va,
                     {2'b00, page_vtag[p], data[15:0]});
      endcase
    end

    if (dut0.checker0.fail_count != 0)
      fail_run("a protocol assertion in the bound checker failed");
    else
    begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
src/cache_geom_pkg.sv
src/cache_ctl_pkg.sv
src/cache_ctrl.sv
src/tlb_array.sv
src/cache_array.sv
src/mem_port.sv
src/cache_top.sv
dv/cache_checker.sv
dv/tb_cache_top.sv

// File: src/cache_array.sv
`default_nettype none

module cache_array (
  input  wire                                CPU_CLK,
  input  wire                                RST,
  input  wire  [cache_geom_pkg::vaddr_w-1:0] vaddr,
  input  wire  [cache_geom_pkg::data_w-1:0]  wdata,
  input  wire  [cache_geom_pkg::ppn_w-1:0]   ppn,
  input  wire                                lookup,
  input  wire                                fill_we,
  input  wire                                hit_we,
  input  wire  [cache_geom_pkg::data_w-1:0]  fill_word,
  input  wire                                fill_sel,
  output logic                               hit,
  output logic [cache_geom_pkg::data_w-1:0]  rdata
);

  logic [cache_geom_pkg::data_w-1:0]      data_mem [cache_geom_pkg::data_depth];
  logic [cache_geom_pkg::ppn_w-1:0]       tag_mem [cache_geom_pkg::line_count];
  logic [cache_geom_pkg::line_count-1:0]  valid;

  logic [cache_geom_pkg::line_idx_w-1:0]  rd_line;
  logic                                   rd_word;
  logic [cache_geom_pkg::line_idx_w-1:0]  line_q;
  logic                                   word_q;
  logic [cache_geom_pkg::data_w-1:0]      wdata_q;
  logic [cache_geom_pkg::ppn_w-1:0]       tag_q;
  logic                                   valid_q;

  logic [cache_geom_pkg::line_idx_w+cache_geom_pkg::word_sel_w-1:0] wr_addr;
  logic [cache_geom_pkg::data_w-1:0]      wr_data;
  logic                                   fill_last;

  assign rd_line = vaddr[cache_geom_pkg::line_idx_lsb +: cache_geom_pkg::line_idx_w];
  assign rd_word = vaddr[cache_geom_pkg::word_sel_bit];

  // Refill beats take the write port ahead of the held request.
  assign wr_addr = fill_we ? {line_q, fill_sel} : {line_q, word_q};
  assign wr_data = fill_we ? fill_word : wdata_q;
  assign fill_last = fill_we && fill_sel; // Odd word closes the refill.

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (fill_last)
        valid[line_q] <= 1'b1;
      if (lookup)
        valid_q <= valid[rd_line];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (fill_we || hit_we)
      data_mem[wr_addr] <= wr_data;
    if (fill_last)
      tag_mem[line_q] <= ppn;
    if (lookup)
    begin
      line_q <= rd_line;
      word_q <= rd_word;
      wdata_q <= wdata;
      tag_q <= tag_mem[rd_line];
      rdata <= data_mem[{rd_line, rd_word}];
    end
    else if (fill_we && (fill_sel == word_q))
      rdata <= fill_word; // Requested word is forwarded from the refill.
  end

  // Tags are physical page numbers from the TLB.
  assign hit = valid_q && (tag_q == ppn);

endmodule

`default_nettype wire

// File: src/cache_ctl_pkg.sv
`default_nettype none

package cache_ctl_pkg;

  typedef enum logic [1:0] {
    op_read     = 2'd0,
    op_write    = 2'd1,
    op_tlb_load = 2'd2
  } cache_op_e;

  // Controller states, one request at a time.
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_lookup    = 3'd1,
    st_refill    = 3'd2,
    st_write_mem = 3'd3,
    st_fill_done = 3'd4,
    st_respond   = 3'd5
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
  input  wire                      CPU_CLK,
  input  wire                      RST,
  input  wire                      req,
  input  wire cache_ctl_pkg::cache_op_e op,
  output logic                     busy,
  output logic                     done,
  output logic                     fault,
  output logic                     lookup,
  output logic                     tlb_we,
  output logic                     fill_we,
  output logic                     hit_we,
  output logic                     mem_start,
  output logic                     mem_write,
  input  wire                      tlb_fault,
  input  wire                      hit,
  input  wire                      beat_valid,
  input  wire                      last
);

  cache_ctl_pkg::ctrl_state_e state;
  cache_ctl_pkg::cache_op_e   op_q;
  logic                       is_write;
  logic                       in_idle;
  logic                       in_lookup;

  assign in_idle = (state == cache_ctl_pkg::st_idle);
  assign in_lookup = (state == cache_ctl_pkg::st_lookup);
  assign is_write = (op_q == cache_ctl_pkg::op_write);

  assign busy = !in_idle;

  // Both arrays sample the request in the cycle of req.
  assign lookup = in_idle && req && (op != cache_ctl_pkg::op_tlb_load);
  assign tlb_we = in_idle && req && (op == cache_ctl_pkg::op_tlb_load);

  // Lookup results are valid while in st_lookup.
  assign hit_we = in_lookup && !tlb_fault && is_write && hit; // Write hits update the word.
  assign mem_start = in_lookup && !tlb_fault && (is_write || !hit);
  assign mem_write = is_write;

  assign fill_we = (state == cache_ctl_pkg::st_refill) && beat_valid;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state <= cache_ctl_pkg::st_idle;
      op_q <= cache_ctl_pkg::op_read;
      done <= 1'b0;
      fault <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        cache_ctl_pkg::st_idle:
        begin
          if (req)
          begin
            op_q <= op;
            fault <= 1'b0;
            if (op == cache_ctl_pkg::op_tlb_load)
              state <= cache_ctl_pkg::st_respond; // Entry is written at req.
            else
              state <= cache_ctl_pkg::st_lookup;
          end
        end
        cache_ctl_pkg::st_lookup:
        begin
          if (tlb_fault)
          begin
            fault <= 1'b1; // No memory access on a fault.
            state <= cache_ctl_pkg::st_respond;
          end
          else if (is_write)
            state <= cache_ctl_pkg::st_write_mem;
          else if (hit)
            state <= cache_ctl_pkg::st_respond;
          else
            state <= cache_ctl_pkg::st_refill;
        end
        cache_ctl_pkg::st_refill:
        begin
          if (last)
            state <= cache_ctl_pkg::st_fill_done;
        end
        cache_ctl_pkg::st_write_mem:
        begin
          if (last)
          begin
            done <= 1'b1;
            state <= cache_ctl_pkg::st_idle;
          end
        end
        cache_ctl_pkg::st_fill_done,
        cache_ctl_pkg::st_respond:
        begin
          done <= 1'b1;
          state <= cache_ctl_pkg::st_idle;
        end
        default:
        begin
          state <= cache_ctl_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  // Word and address widths.
  localparam int unsigned vaddr_w = 32;
  localparam int unsigned paddr_w = 26;
  localparam int unsigned data_w = 32;
  localparam int unsigned ppn_w = 16;
  localparam int unsigned vtag_w = 14;

  localparam int unsigned page_off_w = paddr_w - ppn_w; // Untranslated low address bits.

  // TLB index field of the virtual address.
  localparam int unsigned tlb_idx_lsb = 10;
  localparam int unsigned tlb_idx_w = 8;
  localparam int unsigned vtag_lsb = tlb_idx_lsb + tlb_idx_w; // Virtual tag sits above the index.

  // Cache line index field and word select.
  localparam int unsigned line_idx_lsb = 3;
  localparam int unsigned line_idx_w = 7;
  localparam int unsigned word_sel_bit = 2;

  // Array depths.
  localparam int unsigned tlb_depth = 256;
  localparam int unsigned line_count = 128;
  localparam int unsigned words_per_line = 2;
  localparam int unsigned word_sel_w = $clog2(words_per_line);
  localparam int unsigned data_depth = line_count * words_per_line;

endpackage

`default_nettype wire

// File: src/cache_top.sv
`default_nettype none

module cache_top (
  input  wire                                 CPU_CLK,
  input  wire                                 RST,
  input  wire                                 req,
  input  wire cache_ctl_pkg::cache_op_e       op,
  input  wire  [cache_geom_pkg::vaddr_w-1:0]  vaddr,
  input  wire  [cache_geom_pkg::data_w-1:0]   wdata,
  output logic                                busy,
  output logic                                done,
  output logic [cache_geom_pkg::data_w-1:0]   rdata,
  output logic                                fault,
  output logic                                mem_req,
  output logic                                mem_we,
  output logic [cache_geom_pkg::paddr_w-1:0]  mem_addr,
  output logic [cache_geom_pkg::data_w-1:0]   mem_wdata,
  input  wire                                 mem_ack,
  input  wire  [cache_geom_pkg::data_w-1:0]   mem_rdata
);

  // The processor keeps vaddr and wdata steady while busy is high.
  logic                               lookup;
  logic                               tlb_we;
  logic                               fill_we;
  logic                               hit_we;
  logic                               mem_start;
  logic                               mem_write;
  logic                               tlb_fault;
  logic [cache_geom_pkg::ppn_w-1:0]   ppn;
  logic [cache_geom_pkg::paddr_w-1:0] paddr;
  logic                               hit;
  logic                               beat_valid;
  logic                               fill_sel;
  logic [cache_geom_pkg::data_w-1:0]  fill_word;
  logic                               last;

  cache_ctrl ctrl0 (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .req        (req),
    .op         (op),
    .busy       (busy),
    .done       (done),
    .fault      (fault),
    .lookup     (lookup),
    .tlb_we     (tlb_we),
    .fill_we    (fill_we),
    .hit_we     (hit_we),
    .mem_start  (mem_start),
    .mem_write  (mem_write),
    .tlb_fault  (tlb_fault),
    .hit        (hit),
    .beat_valid (beat_valid),
    .last       (last)
  );

  tlb_array tlb0 (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .vaddr     (vaddr),
    .wdata     (wdata),
    .lookup    (lookup),
    .tlb_we    (tlb_we),
    .tlb_fault (tlb_fault),
    .ppn       (ppn),
    .paddr     (paddr)
  );

  cache_array array0 (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .vaddr     (vaddr),
    .wdata     (wdata),
    .ppn       (ppn),
    .lookup    (lookup),
    .fill_we   (fill_we),
    .hit_we    (hit_we),
    .fill_word (fill_word),
    .fill_sel  (fill_sel),
    .hit       (hit),
    .rdata     (rdata)
  );

  mem_port port0 (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .mem_start  (mem_start),
    .mem_write  (mem_write),
    .paddr      (paddr),
    .wdata      (wdata),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .beat_valid (beat_valid),
    .fill_sel   (fill_sel),
    .fill_word  (fill_word),
    .last       (last)
  );

endmodule

`default_nettype wire

// File: src/mem_port.sv
`default_nettype none

module mem_port (
  input  wire                                 CPU_CLK,
  input  wire                                 RST,
  input  wire                                 mem_start,
  input  wire                                 mem_write,
  input  wire  [cache_geom_pkg::paddr_w-1:0]  paddr,
  input  wire  [cache_geom_pkg::data_w-1:0]   wdata,
  output logic                                mem_req,
  output logic                                mem_we,
  output logic [cache_geom_pkg::paddr_w-1:0]  mem_addr,
  output logic [cache_geom_pkg::data_w-1:0]   mem_wdata,
  input  wire                                 mem_ack,
  input  wire  [cache_geom_pkg::data_w-1:0]   mem_rdata,
  output logic                                beat_valid,
  output logic                                fill_sel,
  output logic [cache_geom_pkg::data_w-1:0]   fill_word,
  output logic                                last
);

  logic beat;
  logic rearm;

  assign beat_valid = mem_req && mem_ack && !mem_we;
  assign last = mem_req && mem_ack && (mem_we || beat);
  assign fill_sel = beat;
  assign fill_word = mem_rdata;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      mem_req <= 1'b0;
      mem_we <= 1'b0;
      beat <= 1'b0;
      rearm <= 1'b0;
    end
    else if (mem_start)
    begin
      mem_req <= 1'b1;
      mem_we <= mem_write;
      beat <= 1'b0;
      rearm <= 1'b0;
    end
    else if (mem_req && mem_ack)
    begin
      mem_req <= 1'b0;
      mem_we <= 1'b0;
      if (!mem_we && !beat)
      begin
        beat <= 1'b1;
        rearm <= 1'b1; // Odd word goes out after one idle cycle.
      end
    end
    else if (rearm)
    begin
      mem_req <= 1'b1;
      rearm <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (mem_start)
    begin
      if (mem_write)
        mem_addr <= paddr;
      else
        mem_addr <= {paddr[cache_geom_pkg::paddr_w-1:cache_geom_pkg::line_idx_lsb],
                     {cache_geom_pkg::line_idx_lsb{1'b0}}}; // Refill starts at the even word.
      mem_wdata <= wdata;
    end
    else if (beat_valid && !beat)
      mem_addr[cache_geom_pkg::word_sel_bit] <= 1'b1;
  end

endmodule

`default_nettype wire

// File: src/tlb_array.sv
`default_nettype none

module tlb_array (
  input  wire                                 CPU_CLK,
  input  wire                                 RST,
  input  wire  [cache_geom_pkg::vaddr_w-1:0]  vaddr,
  input  wire  [cache_geom_pkg::data_w-1:0]   wdata,
  input  wire                                 lookup,
  input  wire                                 tlb_we,
  output logic                                tlb_fault,
  output logic [cache_geom_pkg::ppn_w-1:0]    ppn,
  output logic [cache_geom_pkg::paddr_w-1:0]  paddr
);

  logic [cache_geom_pkg::vtag_w-1:0]     vtag_mem [cache_geom_pkg::tlb_depth];
  logic [cache_geom_pkg::ppn_w-1:0]      ppn_mem [cache_geom_pkg::tlb_depth];
  logic [cache_geom_pkg::tlb_depth-1:0]  valid;

  logic [cache_geom_pkg::tlb_idx_w-1:0]  idx;
  logic [cache_geom_pkg::vtag_w-1:0]     vtag_q;
  logic                                  valid_q;
  logic [cache_geom_pkg::vtag_w-1:0]     req_vtag_q;
  logic [cache_geom_pkg::page_off_w-1:0] page_off_q;

  // Lookups and TLB loads both take their index from vaddr.
  assign idx = vaddr[cache_geom_pkg::tlb_idx_lsb +: cache_geom_pkg::tlb_idx_w];

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (tlb_we)
        valid[idx] <= 1'b1;
      if (lookup)
        valid_q <= valid[idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (tlb_we)
    begin
      vtag_mem[idx] <= wdata[cache_geom_pkg::ppn_w +: cache_geom_pkg::vtag_w];
      ppn_mem[idx] <= wdata[cache_geom_pkg::ppn_w-1:0];
    end
    if (lookup)
    begin
      vtag_q <= vtag_mem[idx];
      ppn <= ppn_mem[idx];
      req_vtag_q <= vaddr[cache_geom_pkg::vtag_lsb +: cache_geom_pkg::vtag_w];
      page_off_q <= vaddr[cache_geom_pkg::page_off_w-1:0];
    end
  end

  assign tlb_fault = !valid_q || (vtag_q != req_vtag_q);

  assign paddr = {ppn, page_off_q}; // Page offset passes untranslated.

endmodule

`default_nettype wire
